//--- rp_sys_pkg.sv
// system bus definitions: widths, region map, housekeeping offsets, address layout

package rp_sys_pkg;

  // bus widths
  localparam int unsigned SYS_AW       = 32;
  localparam int unsigned SYS_DW       = 32;
  localparam int unsigned SYS_OFFSET_W = 20;                  // byte offset inside a region
  localparam int unsigned SYS_REGION_W = 3;
  localparam int unsigned SYS_REGIONS  = 1 << SYS_REGION_W;   // 8 regions

  // region numbers
  localparam int unsigned REG_HK    = 0;  // housekeeping
  localparam int unsigned REG_SCOPE = 1;  // sample readback
  localparam int unsigned REG_PID   = 3;  // controller stub, acks with zero

  // housekeeping offsets
  localparam logic [SYS_OFFSET_W-1:0] HK_OFS_ID   = 'h0;
  localparam logic [SYS_OFFSET_W-1:0] HK_OFS_LOOP = 'h4;
  localparam logic [SYS_OFFSET_W-1:0] HK_OFS_LED  = 'h8;

  // readback offsets
  localparam logic [SYS_OFFSET_W-1:0] SCOPE_OFS_A = 'h0;
  localparam logic [SYS_OFFSET_W-1:0] SCOPE_OFS_B = 'h4;

  localparam logic [SYS_DW-1:0] HK_ID = 32'h5250_4131;  // board id word

  // one address word, seen raw or split into region and offset
  typedef union packed {
    logic [SYS_AW-1:0] raw;
    struct packed {
      logic [SYS_AW-SYS_REGION_W-SYS_OFFSET_W-1:0] unused;  // top 9 bits, ignored
      logic [SYS_REGION_W-1:0]                     region;
      logic [SYS_OFFSET_W-1:0]                     offset;
    } fld;
  } sys_addr_u;

endpackage

//--- rp_analog_pkg.sv
// analog path definitions: sample widths, sample and sum types, DAC full-scale codes

package rp_analog_pkg;

  // converter widths
  localparam int unsigned ADC_DW   = 14;  // sample width
  localparam int unsigned ADC_TRIM = 2;   // low ADC bits forced to zero
  localparam int unsigned LED_W    = 8;

  // signed stream sample, as used by generator and controller
  typedef logic signed [ADC_DW-1:0] sample_t;

  // one bit of headroom for the generator + controller sum
  typedef logic signed [ADC_DW:0] sum_t;

  //////////////////////////////////////////////////
  // DAC full-scale codes
  //////////////////////////////////////////////////

  // the DAC takes the inverted two's complement word,
  // so these are the clamp limits after inversion
  localparam logic [ADC_DW-1:0] DAC_POS_FULL = 'h2000;  // ~(+8191)
  localparam logic [ADC_DW-1:0] DAC_NEG_FULL = 'h1FFF;  // ~(-8192)

endpackage

//--- sys_region_if.sv
// decoded system bus request, from the address decoder to region slaves and result stage
`timescale 1ns/100ps

interface sys_region_if;

  import rp_sys_pkg::*;

  // one-hot region select, zero when there is no request
  logic [SYS_REGIONS-1:0]  sel;
  logic [SYS_OFFSET_W-1:0] offset;  // byte offset inside the region
  logic [SYS_DW-1:0]       wdata;
  logic                    wen;     // single cycle write strobe
  logic                    ren;     // single cycle read strobe

  // decoder drives everything
  modport decode (
    output sel, offset, wdata, wen, ren
  );

  // register slaves, reads are combinational on offset
  modport slave (
    input sel, offset, wdata, wen
  );

  // ack, err and read mux stage
  modport result (
    input sel, wen, ren
  );

endinterface

//--- sys_bus_decode.sv
// system bus address decoder, splits the address into region and offset
`timescale 1ns/100ps

module sys_bus_decode (
  input  rp_sys_pkg::sys_addr_u                 sys_addr_i,   // byte address
  input  logic [rp_sys_pkg::SYS_DW-1:0]         sys_wdata_i,
  input  logic                                  sys_wen_i,    // write strobe
  input  logic                                  sys_ren_i,    // read strobe
  sys_region_if.decode                          bus
);

  import rp_sys_pkg::*;

  logic                    req;        // any access this cycle
  logic [SYS_REGION_W-1:0] region;
  logic [SYS_REGIONS-1:0]  sel_hot;    // ungated one-hot

  //////////////////////////////////////////////////
  // region select
  //////////////////////////////////////////////////

  assign req    = sys_wen_i | sys_ren_i;
  assign region = sys_addr_i.fld.region;  // bits above the offset field

  always_comb
  begin
    sel_hot         = '0;
    sel_hot[region] = 1'b1;
  end

  // select only rises for a real request,
  // so an idle bus never looks like a region access
  assign bus.sel = req ? sel_hot : '0;

  //////////////////////////////////////////////////
  // pass-through of request payload
  //////////////////////////////////////////////////

  // low bits of the raw word are the in-region offset
  assign bus.offset = sys_addr_i.raw[SYS_OFFSET_W-1:0];
  assign bus.wdata  = sys_wdata_i;
  assign bus.wen    = sys_wen_i;
  assign bus.ren    = sys_ren_i;

endmodule

//--- hk_regs.sv
// housekeeping register file: id word, digital loopback control and LED byte
`timescale 1ns/100ps

module hk_regs (
  input  logic                              adc_clk,
  input  logic                              rst_n_i,         // async, active low
  sys_region_if.slave                       bus,
  output logic                              digital_loop_o,  // dac -> adc loopback
  output logic [rp_analog_pkg::LED_W-1:0]   led_o,
  output logic [rp_sys_pkg::SYS_DW-1:0]     rdata_o          // read word for current offset
);

  import rp_sys_pkg::*;
  import rp_analog_pkg::*;

  logic hk_sel;  // region 0 addressed
  logic hk_wr;

  assign hk_sel = bus.sel[REG_HK];
  assign hk_wr  = hk_sel & bus.wen;

  //////////////////////////////////////////////////
  // write side
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      digital_loop_o <= 1'b0;
      led_o          <= '0;
    end
    else if (hk_wr)
    begin
      case (bus.offset)
        HK_OFS_LOOP: digital_loop_o <= bus.wdata[0];
        HK_OFS_LED:  led_o          <= bus.wdata[LED_W-1:0];
        default:     ;  // id and unknown offsets drop the write
      endcase
    end
  end

  //////////////////////////////////////////////////
  // read side
  //////////////////////////////////////////////////

  // combinational, so a read sees the value before
  // a write landing at the same edge
  always_comb
  begin
    rdata_o = '0;
    if (hk_sel)
    begin
      case (bus.offset)
        HK_OFS_ID:   rdata_o = HK_ID;
        HK_OFS_LOOP: rdata_o = {{(SYS_DW-1){1'b0}}, digital_loop_o};
        HK_OFS_LED:  rdata_o = {{(SYS_DW-LED_W){1'b0}}, led_o};
        default:     rdata_o = '0;  // unmapped reads zero
      endcase
    end
  end

endmodule

//--- adc_frontend.sv
// ADC front end: channel swap, low bit trim, digital loopback and sample readback
`timescale 1ns/100ps

module adc_frontend #(
  parameter int unsigned DW = rp_analog_pkg::ADC_DW  // sample width
)(
  input  logic                           adc_clk,
  input  logic                           rst_n_i,
  input  logic [DW-1:0]                  adc_dat_a_i,     // raw ADC ch A
  input  logic [DW-1:0]                  adc_dat_b_i,     // raw ADC ch B
  input  logic [DW-1:0]                  dac_code_a_i,    // loopback source ch A
  input  logic [DW-1:0]                  dac_code_b_i,    // loopback source ch B
  input  logic                           digital_loop_i,
  sys_region_if.slave                    bus,
  output logic [rp_sys_pkg::SYS_DW-1:0]  rdata_o
);

  import rp_sys_pkg::*;
  import rp_analog_pkg::*;

  logic signed [DW-1:0] smp_a;  // acquired ch A
  logic signed [DW-1:0] smp_b;  // acquired ch B

  //////////////////////////////////////////////////
  // acquisition register
  //////////////////////////////////////////////////

  // inputs are crossed on the board, ADC B feeds ch A and vice versa
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      smp_a <= '0;
      smp_b <= '0;
    end
    else
    begin
      smp_a <= digital_loop_i ? dac_code_a_i : {adc_dat_b_i[DW-1:ADC_TRIM], {ADC_TRIM{1'b0}}};
      smp_b <= digital_loop_i ? dac_code_b_i : {adc_dat_a_i[DW-1:ADC_TRIM], {ADC_TRIM{1'b0}}};
    end
  end

  //////////////////////////////////////////////////
  // region 1 readback
  //////////////////////////////////////////////////

  always_comb
  begin
    rdata_o = '0;
    if (bus.sel[REG_SCOPE])  // read only, writes have no effect
    begin
      case (bus.offset)
        SCOPE_OFS_A: rdata_o = {{(SYS_DW-DW){smp_a[DW-1]}}, smp_a};  // sign extended
        SCOPE_OFS_B: rdata_o = {{(SYS_DW-DW){smp_b[DW-1]}}, smp_b};
        default:     rdata_o = '0;
      endcase
    end
  end

endmodule

//--- dac_backend.sv
// DAC back end: stream sum, clamp, code inversion, output registers and DAC reset
`timescale 1ns/100ps

module dac_backend #(
  parameter int unsigned DW = rp_analog_pkg::ADC_DW  // sample width
)(
  input  logic                  adc_clk,
  input  logic                  rst_n_i,
  input  logic signed [DW-1:0]  asg_a_i,       // generator ch A
  input  logic signed [DW-1:0]  asg_b_i,       // generator ch B
  input  logic signed [DW-1:0]  pid_a_i,       // controller ch A
  input  logic signed [DW-1:0]  pid_b_i,       // controller ch B
  output logic [DW-1:0]         dac_code_a_o,  // unregistered, for loopback
  output logic [DW-1:0]         dac_code_b_o,
  output logic [1:0][DW-1:0]    dac_dat_o,     // [0] carries ch B, [1] carries ch A
  output logic                  dac_reset_o
);

  import rp_analog_pkg::*;

  sum_t          sum_a;       // one bit of headroom
  sum_t          sum_b;
  logic [DW-1:0] dac_dat_a;   // stage register
  logic [DW-1:0] dac_dat_b;

  // clamp to the 14 bit range, then invert into DAC code
  function automatic logic [DW-1:0] sat_inv(input sum_t s);
    logic pos_ovf;
    logic neg_ovf;
    pos_ovf = ~s[DW] &  s[DW-1];  // top two bits disagree, sign says positive
    neg_ovf =  s[DW] & ~s[DW-1];
    if (pos_ovf)
      return DAC_POS_FULL;
    else if (neg_ovf)
      return DAC_NEG_FULL;
    else
      return ~s[DW-1:0];
  endfunction

  //////////////////////////////////////////////////
  // sum and saturation
  //////////////////////////////////////////////////

  assign sum_a = sum_t'(asg_a_i) + sum_t'(pid_a_i);  // sign extended before add
  assign sum_b = sum_t'(asg_b_i) + sum_t'(pid_b_i);

  assign dac_code_a_o = sat_inv(sum_a);
  assign dac_code_b_o = sat_inv(sum_b);

  //////////////////////////////////////////////////
  // output pipeline
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      dac_dat_a <= '0;
      dac_dat_b <= '0;
      dac_dat_o <= '0;
    end
    else
    begin
      dac_dat_a    <= dac_code_a_o;
      dac_dat_b    <= dac_code_b_o;
      dac_dat_o[0] <= dac_dat_b;  // ch B drives DAC port 0
      dac_dat_o[1] <= dac_dat_a;  // ch A drives DAC port 1
    end
  end

  // DAC held in reset, released one edge after the design
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      dac_reset_o <= 1'b1;
    else
      dac_reset_o <= 1'b0;
  end

endmodule

//--- sys_bus_result.sv
// bus result stage: ack, err and read data one cycle after each request
`timescale 1ns/100ps

module sys_bus_result (
  input  logic                           adc_clk,
  input  logic                           rst_n_i,
  sys_region_if.result                   bus,
  input  logic [rp_sys_pkg::SYS_DW-1:0]  hk_rdata_i,     // region 0 read word
  input  logic [rp_sys_pkg::SYS_DW-1:0]  scope_rdata_i,  // region 1 read word
  output logic [rp_sys_pkg::SYS_DW-1:0]  sys_rdata_o,
  output logic                           sys_ack_o,
  output logic                           sys_err_o
);

  import rp_sys_pkg::*;

  logic              req;       // request seen this cycle
  logic              mapped;    // region has a responder
  logic [SYS_DW-1:0] rdata_nxt;

  assign req    = bus.wen | bus.ren;
  assign mapped = bus.sel[REG_HK] | bus.sel[REG_SCOPE] | bus.sel[REG_PID];

  //////////////////////////////////////////////////
  // ack and error
  //////////////////////////////////////////////////

  // every request acks, fixed one cycle latency,
  // so back to back requests pipeline without stalls
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      sys_ack_o <= 1'b0;
      sys_err_o <= 1'b0;
    end
    else
    begin
      sys_ack_o <= req;
      sys_err_o <= req & ~mapped;  // regions 2, 4..7
    end
  end

  //////////////////////////////////////////////////
  // read data
  //////////////////////////////////////////////////

  always_comb
  begin
    rdata_nxt = '0;                 // writes, stub and error regions
    if (bus.ren)
    begin
      if (bus.sel[REG_HK])
        rdata_nxt = hk_rdata_i;
      else if (bus.sel[REG_SCOPE])
        rdata_nxt = scope_rdata_i;
    end
  end

  always_ff @(posedge adc_clk)
  begin
    sys_rdata_o <= rdata_nxt;       // only meaningful with ack
  end

endmodule

//--- rp_analog_top.sv
// analog top: system bus regions, ADC front end and DAC back end on adc_clk
`timescale 1ns/100ps

module rp_analog_top (
  input  logic                                       adc_clk,
  input  logic                                       rst_n_i,      // async, active low
  // system bus
  input  logic [rp_sys_pkg::SYS_AW-1:0]              sys_addr_i,
  input  logic [rp_sys_pkg::SYS_DW-1:0]              sys_wdata_i,
  input  logic                                       sys_wen_i,
  input  logic                                       sys_ren_i,
  output logic [rp_sys_pkg::SYS_DW-1:0]              sys_rdata_o,
  output logic                                       sys_ack_o,
  output logic                                       sys_err_o,
  // ADC
  input  logic [rp_analog_pkg::ADC_DW-1:0]           adc_dat_a_i,
  input  logic [rp_analog_pkg::ADC_DW-1:0]           adc_dat_b_i,
  // sample streams
  input  rp_analog_pkg::sample_t                     asg_a_i,      // generator
  input  rp_analog_pkg::sample_t                     asg_b_i,
  input  rp_analog_pkg::sample_t                     pid_a_i,      // controller
  input  rp_analog_pkg::sample_t                     pid_b_i,
  // DAC
  output logic [1:0][rp_analog_pkg::ADC_DW-1:0]      dac_dat_o,
  output logic                                       dac_reset_o,
  output logic [rp_analog_pkg::LED_W-1:0]            led_o
);

  import rp_sys_pkg::*;
  import rp_analog_pkg::*;

  logic [ADC_DW-1:0] dac_code_a;    // inverted code, loopback source
  logic [ADC_DW-1:0] dac_code_b;
  logic              digital_loop;
  logic [SYS_DW-1:0] hk_rdata;
  logic [SYS_DW-1:0] scope_rdata;

  sys_region_if region_bus ();

  //////////////////////////////////////////////////
  // system bus
  //////////////////////////////////////////////////

  sys_bus_decode i_decode (
    .sys_addr_i  (sys_addr_i ),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i  ),
    .sys_ren_i   (sys_ren_i  ),
    .bus         (region_bus )
  );

  hk_regs i_hk (
    .adc_clk        (adc_clk     ),
    .rst_n_i        (rst_n_i     ),
    .bus            (region_bus  ),
    .digital_loop_o (digital_loop),
    .led_o          (led_o       ),
    .rdata_o        (hk_rdata    )
  );

  sys_bus_result i_result (
    .adc_clk       (adc_clk    ),
    .rst_n_i       (rst_n_i    ),
    .bus           (region_bus ),
    .hk_rdata_i    (hk_rdata   ),
    .scope_rdata_i (scope_rdata),
    .sys_rdata_o   (sys_rdata_o),
    .sys_ack_o     (sys_ack_o  ),
    .sys_err_o     (sys_err_o  )
  );

  //////////////////////////////////////////////////
  // analog path
  //////////////////////////////////////////////////

  adc_frontend #(.DW (ADC_DW)) i_adc (
    .adc_clk        (adc_clk     ),
    .rst_n_i        (rst_n_i     ),
    .adc_dat_a_i    (adc_dat_a_i ),
    .adc_dat_b_i    (adc_dat_b_i ),
    .dac_code_a_i   (dac_code_a  ),
    .dac_code_b_i   (dac_code_b  ),
    .digital_loop_i (digital_loop),
    .bus            (region_bus  ),
    .rdata_o        (scope_rdata )
  );

  dac_backend #(.DW (ADC_DW)) i_dac (
    .adc_clk      (adc_clk    ),
    .rst_n_i      (rst_n_i    ),
    .asg_a_i      (asg_a_i    ),
    .asg_b_i      (asg_b_i    ),
    .pid_a_i      (pid_a_i    ),
    .pid_b_i      (pid_b_i    ),
    .dac_code_a_o (dac_code_a ),
    .dac_code_b_o (dac_code_b ),
    .dac_dat_o    (dac_dat_o  ),
    .dac_reset_o  (dac_reset_o)
  );

endmodule

//--- tb_rp_analog_top.sv
// testbench for the analog top, random bus and stream traffic checked against a model
`timescale 1ns/100ps

module tb_rp_analog_top;

  import rp_sys_pkg::*;
  import rp_analog_pkg::*;

  localparam int          CLK_PERIOD = 20;
  localparam int          DRIVE_DLY  = 2;       // input change after rising edge
  localparam int          RST_CYCLES = 4;
  localparam logic [31:0] SEED       = 32'd60;
  localparam int N_DAC   = 150;
  localparam int N_HK    = 200;
  localparam int N_SCOPE = 100;
  localparam int N_LOOP  = 100;
  localparam int N_ERR   = 80;
  localparam int TOTAL_CYCLES = RST_CYCLES + N_DAC + N_HK + N_SCOPE + N_LOOP + N_ERR + 8;
  localparam int TIMEOUT      = (TOTAL_CYCLES + 100) * CLK_PERIOD;  // with margin
  localparam logic [ADC_DW-1:0] TRIM_MASK = '1 << ADC_TRIM;

  logic                    adc_clk;
  logic                    rst_n_i;
  logic [SYS_AW-1:0]       sys_addr_i;
  logic [SYS_DW-1:0]       sys_wdata_i;
  logic                    sys_wen_i;
  logic                    sys_ren_i;
  logic [SYS_DW-1:0]       sys_rdata_o;
  logic                    sys_ack_o;
  logic                    sys_err_o;
  logic [ADC_DW-1:0]       adc_dat_a;
  logic [ADC_DW-1:0]       adc_dat_b;
  sample_t                 asg_a, asg_b, pid_a, pid_b;
  logic [1:0][ADC_DW-1:0]  dac_dat_o;
  logic                    dac_reset_o;
  logic [LED_W-1:0]        led_o;
  logic [31:0]             lfsr;             // random state

  // model state
  logic                    m_loop;
  logic [LED_W-1:0]        m_led;
  logic [ADC_DW-1:0]       m_smp_a, m_smp_b;  // acquired samples
  logic [ADC_DW-1:0]       m_st_a, m_st_b;    // DAC stage
  logic [ADC_DW-1:0]       m_out_a, m_out_b;  // DAC outputs
  // request in flight
  logic                    pend_req, pend_wr, pend_err;
  logic [SYS_REGION_W-1:0] pend_region;
  logic [SYS_OFFSET_W-1:0] pend_offset;
  logic [SYS_DW-1:0]       pend_wdata, pend_rdata;

  rp_analog_top rp_analog_top_inst (
    .adc_clk     (adc_clk    ),
    .rst_n_i     (rst_n_i    ),
    .sys_addr_i  (sys_addr_i ),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i  ),
    .sys_ren_i   (sys_ren_i  ),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o  ),
    .sys_err_o   (sys_err_o  ),
    .adc_dat_a_i (adc_dat_a  ),
    .adc_dat_b_i (adc_dat_b  ),
    .asg_a_i     (asg_a      ),
    .asg_b_i     (asg_b      ),
    .pid_a_i     (pid_a      ),
    .pid_b_i     (pid_b      ),
    .dac_dat_o   (dac_dat_o  ),
    .dac_reset_o (dac_reset_o),
    .led_o       (led_o      )
  );

  initial
  begin
    adc_clk = 1'b0;
    forever #(CLK_PERIOD/2) adc_clk = ~adc_clk;
  end

  //////////////////////////////////////////////////
  // random source and reference rules
  //////////////////////////////////////////////////

  // galois step, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);   // one step per bit
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // add, clamp to the 14 bit range, then invert
  function automatic logic [ADC_DW-1:0] dac_code_model(input sample_t g, input sample_t c);
    int s;
    s = int'(g) + int'(c);
    if (s > 8191)
      s = 8191;
    else if (s < -8192)
      s = -8192;
    return ~s[ADC_DW-1:0];
  endfunction

  function automatic logic [SYS_DW-1:0] sext32(input sample_t s);
    int v;
    v = s;
    return v;
  endfunction

  function automatic logic [SYS_DW-1:0] expected_read(input logic [SYS_REGION_W-1:0] region,
                                                      input logic [SYS_OFFSET_W-1:0] offset);
    logic [SYS_DW-1:0] v;
    v = '0;                               // stub, error and unknown offsets
    if (region == REG_HK)
    begin
      if (offset == HK_OFS_ID)        v = HK_ID;
      else if (offset == HK_OFS_LOOP) v = m_loop;
      else if (offset == HK_OFS_LED)  v = m_led;
    end
    else if (region == REG_SCOPE)
    begin
      if (offset == SCOPE_OFS_A)      v = sext32(m_smp_a);
      else if (offset == SCOPE_OFS_B) v = sext32(m_smp_b);
    end
    return v;
  endfunction

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected)
    begin
      $display("MISMATCH at %0t ns: %s expected %h got %h", $time, what, expected, actual);
      $display("SIMULATION FAILED");
      $fatal(1, "check failed");
    end
  endtask

  //////////////////////////////////////////////////
  // per cycle driver and model step
  //////////////////////////////////////////////////

  task automatic drive_streams();
    logic [1:0] mode;
    mode = rand_bits(2);
    case (mode)
      2'd1:                               // every sum overflows positive
      begin
        asg_a = sample_t'(14'h1000 | rand_bits(12));
        asg_b = sample_t'(14'h1000 | rand_bits(12));
        pid_a = sample_t'(14'h1000 | rand_bits(12));
        pid_b = sample_t'(14'h1000 | rand_bits(12));
      end
      2'd2:                               // every sum overflows negative
      begin
        asg_a = sample_t'(14'h2000 | rand_bits(12));
        asg_b = sample_t'(14'h2000 | rand_bits(12));
        pid_a = sample_t'(14'h2000 | rand_bits(12));
        pid_b = sample_t'(14'h2000 | rand_bits(12));
      end
      default:
      begin
        asg_a = sample_t'(rand_bits(ADC_DW));
        asg_b = sample_t'(rand_bits(ADC_DW));
        pid_a = sample_t'(rand_bits(ADC_DW));
        pid_b = sample_t'(rand_bits(ADC_DW));
      end
    endcase
    adc_dat_a = rand_bits(ADC_DW);
    adc_dat_b = rand_bits(ADC_DW);
  endtask

  task automatic tick();
    logic [ADC_DW-1:0] code_a;
    logic [ADC_DW-1:0] code_b;
    logic              exp_ack;
    logic              exp_err;
    logic              exp_rd;
    @(posedge adc_clk);
    #(DRIVE_DLY);
    exp_ack = pend_req;                   // answer to the cycle just ended
    exp_err = pend_req & pend_err;
    exp_rd  = pend_req & ~pend_wr;
    code_a  = dac_code_model(asg_a, pid_a);
    code_b  = dac_code_model(asg_b, pid_b);
    // channels cross, loopback from before this edge
    m_smp_a = m_loop ? code_a : (adc_dat_b & TRIM_MASK);
    m_smp_b = m_loop ? code_b : (adc_dat_a & TRIM_MASK);
    m_out_a = m_st_a;
    m_out_b = m_st_b;
    m_st_a  = code_a;
    m_st_b  = code_b;
    if (pend_req && pend_wr && pend_region == REG_HK)
    begin
      if (pend_offset == HK_OFS_LOOP)
        m_loop = pend_wdata[0];
      else if (pend_offset == HK_OFS_LED)
        m_led = pend_wdata[LED_W-1:0];
    end
    pend_req = 1'b0;
    check_equal(sys_ack_o, exp_ack, "bus ack");
    check_equal(sys_err_o, exp_err, "bus err");
    if (exp_rd)
      check_equal(sys_rdata_o, pend_rdata, "bus read data");
    check_equal(dac_dat_o[1], m_out_a, "dac port 1 (ch A)");
    check_equal(dac_dat_o[0], m_out_b, "dac port 0 (ch B)");
    check_equal(led_o, m_led, "leds");
    check_equal(dac_reset_o, 1'b0, "dac reset after release");
    sys_wen_i = 1'b0;                     // idle unless a request follows
    sys_ren_i = 1'b0;
    drive_streams();
  endtask

  task automatic issue_request(input logic [SYS_REGION_W-1:0] region,
                               input logic [SYS_OFFSET_W-1:0] offset,
                               input logic wr, input logic [SYS_DW-1:0] wdata);
    logic [8:0] hi;
    hi          = rand_bits(9);           // unused address bits, must be ignored
    sys_addr_i  = {hi, region, offset};
    sys_wdata_i = wdata;
    sys_wen_i   = wr;
    sys_ren_i   = ~wr;
    pend_req    = 1'b1;
    pend_wr     = wr;
    pend_region = region;
    pend_offset = offset;
    pend_wdata  = wdata;
    pend_err    = !(region == REG_HK || region == REG_SCOPE || region == REG_PID);
    pend_rdata  = expected_read(region, offset);  // state before the write lands
  endtask

  task automatic set_loopback(input logic on);
    tick();
    issue_request(REG_HK, HK_OFS_LOOP, 1'b1, {31'b0, on});
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  task automatic apply_reset();
    repeat (RST_CYCLES)
    begin
      @(posedge adc_clk);
      #(DRIVE_DLY);
      check_equal(dac_reset_o, 1'b1, "dac reset in reset");
      check_equal(sys_ack_o, 1'b0, "ack in reset");
      check_equal(sys_err_o, 1'b0, "err in reset");
      check_equal(led_o, '0, "leds in reset");
      check_equal({dac_dat_o[1], dac_dat_o[0]}, '0, "dac data in reset");
    end
    rst_n_i = 1'b1;
    check_equal(dac_reset_o, 1'b1, "dac reset before first edge");  // falls one edge later
  endtask

  task automatic hk_traffic();
    logic [1:0] ofs_sel;
    repeat (N_HK)
    begin
      tick();
      if (rand_bits(3) != 0)              // mostly back to back
      begin
        ofs_sel = rand_bits(2);           // id, loop, led, unknown 0xC
        issue_request(REG_HK, {ofs_sel, 2'b00}, rand_bits(1), rand_bits(32));
      end
    end
  endtask

  task automatic sample_reads(input int n);
    repeat (n)
    begin
      tick();
      if (rand_bits(2) != 0)
        issue_request(REG_SCOPE, {rand_bits(1), 2'b00}, 1'b0, '0);
    end
  endtask

  task automatic unmapped_traffic();
    logic [SYS_REGION_W-1:0] region;
    repeat (N_ERR)
    begin
      tick();
      region = 2 + (rand_bits(3) % 6);    // 2 .. 7, 3 is the stub
      issue_request(region, {rand_bits(4), 2'b00}, rand_bits(1), rand_bits(32));
    end
  endtask

  initial
  begin
    lfsr        = SEED;
    rst_n_i     = 1'b0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    adc_dat_a   = '0;
    adc_dat_b   = '0;
    asg_a       = '0;
    asg_b       = '0;
    pid_a       = '0;
    pid_b       = '0;
    {m_loop, m_led, m_smp_a, m_smp_b} = '0;
    {m_st_a, m_st_b, m_out_a, m_out_b} = '0;
    {pend_req, pend_wr, pend_err, pend_region, pend_offset, pend_wdata, pend_rdata} = '0;
    apply_reset();
    repeat (N_DAC) tick();                // streams only, bus idle
    hk_traffic();
    set_loopback(1'b0);
    sample_reads(N_SCOPE);                // raw ADC samples
    set_loopback(1'b1);
    sample_reads(N_LOOP);                 // DAC codes looped back
    unmapped_traffic();
    repeat (4) tick();                    // drain last answers
    $display("SIMULATION PASSED");
    $finish;
  end

  // watchdog
  initial
  begin
    #(TIMEOUT);
    $display("watchdog timeout, the test sequence did not finish in time");
    $display("SIMULATION FAILED");
    $fatal(1, "timeout");
  end

endmodule

//--- rp_analog.f
rp_sys_pkg.sv
rp_analog_pkg.sv
sys_region_if.sv
sys_bus_decode.sv
hk_regs.sv
adc_frontend.sv
dac_backend.sv
sys_bus_result.sv
rp_analog_top.sv
tb_rp_analog_top.sv

//--- Bender.yml
package:
  name: rp_analog

sources:
  - files:
      - rp_sys_pkg.sv
      - rp_analog_pkg.sv
      - sys_region_if.sv
      - sys_bus_decode.sv
      - hk_regs.sv
      - adc_frontend.sv
      - dac_backend.sv
      - sys_bus_result.sv
      - rp_analog_top.sv
  - target: simulation
    files:
      - tb_rp_analog_top.sv
